// File: verification/pager_input.txt
# columns, all hex: op user addr data exp_paddr exp_fail
# op 0 set model word, 1 reg write, 2 reg read, 3 mem read, 4 mem write, 5 check model word, 6 idle cycles
0 0 012345 123456789 0 0
3 0 12345 123456789 012345 0
1 0 4 000001000 0 0
1 0 5 000001040 0 0
1 0 6 000002000 0 0
1 0 7 000002040 0 0
1 0 0 000000001 0 0
6 0 0 104 0 0
2 0 4 000001000 0 0
2 0 7 000002040 0 0
2 0 0 000000001 0 0
2 0 3 000000000 0 0
0 0 001002 404472345 0 0
0 0 0d1523 abcde0123 0 0
3 0 01523 abcde0123 0d1523 0
5 0 001002 404470345 0 0
0 0 001002 404470346 0 0
0 0 0d1923 111222333 0 0
3 0 01523 abcde0123 0d1523 0
1 0 2 000001403 0 0
3 0 01523 111222333 0d1923 0
4 0 01523 5a5a5a5a5 0d1923 0
5 0 0d1923 5a5a5a5a5 0 0
0 0 002041 408000201 0 0
3 1 20c10 0 0 1
2 0 1 400020c10 0 0
4 1 20bff 0 0 1
2 0 1 d00020bff 0 0
0 0 0803ff 777000777 0 0
3 1 20bff 777000777 0803ff 0
0 0 002008 c10000000 0 0
0 0 100055 246813579 0 0
3 1 04055 246813579 100055 0
0 0 002008 c10040000 0 0
0 0 100455 13579bdf0 0 0
3 1 04055 246813579 100055 0
1 0 6 000002000 0 0
6 0 0 104 0 0
2 0 6 000002000 0 0
3 1 04055 13579bdf0 100455 0

// File: list.f
source/pager_pkg.sv
source/pager_ifs.sv
source/pager_regs.sv
source/page_cache.sv
source/table_walker.sv
source/pager_top.sv
verification/pager_sva.sv
verification/pager_tb.sv

// File: verification/pager_tb.sv
// pager testbench with clock, reset, memory model, file-driven stimulus and compare tasks
`timescale 1ns/10ps
`default_nettype none

module pager_tb import pager_pkg::*; ();

   localparam int TIMEOUT = 200;   // cycles allowed for any one wait
   localparam int unsigned SEED = 32'h28cf_99ae;

   logic     clk;
   logic     reset;
   vaddr_t   mem_addr;
   logic     mem_user;
   logic     mem_read;
   logic     mem_write;
   word_t    mem_write_data;
   word_t    mem_read_data;
   logic     read_ack;
   logic     write_ack;
   logic     page_fail;
   reg_sel_t io_sel;
   logic     io_read;
   logic     io_write;
   word_t    io_write_data;
   word_t    io_read_data;
   paddr_t   pmem_addr;
   word_t    pmem_write_data;
   logic     pmem_read;
   logic     pmem_write;
   word_t    pmem_read_data = '0;
   logic     pmem_read_ack;
   logic     pmem_write_ack;

   word_t       pmem [paddr_t];     // sparse physical memory model
   int unsigned delay_left = 0;     // cycles until the pending request is acked

   pager_top dut (.*);

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // untouched locations return a pattern built from the whole address
   function automatic word_t model_word(input paddr_t addr);
      if (pmem.exists(addr))
         return pmem[addr];
      return {addr[13:0], addr};
   endfunction

   assign pmem_read_ack  = pmem_read && delay_left == 0;
   assign pmem_write_ack = pmem_write && delay_left == 0;

   // every ack delay is drawn from this one seeded stream
   initial begin
      void'($urandom(SEED));
      forever begin
         @(posedge clk);
         if (reset) begin
            delay_left <= 0;
         end else if (pmem_read || pmem_write) begin
            if (delay_left == 0) begin
               if (pmem_write)
                  pmem[pmem_addr] = pmem_write_data;
               delay_left <= $urandom_range(3, 0);   // delay for the next request
            end else begin
               delay_left <= delay_left - 1;
            end
         end
      end
   end

   always @(posedge clk) begin
      #2;
      pmem_read_data = model_word(pmem_addr);   // settled well before the next edge
   end

   task automatic report_failure(input string why);
      $display("%s", why);
      $display("test failed");
      $fatal(1);
   endtask

   always @(posedge clk) begin
      if (dut.u_sva.error_count != 0)
         report_failure("a concurrent assertion failed");
   end

   task automatic check_word(input word_t got, input word_t exp, input string what);
      if (got !== exp)
         report_failure($sformatf("CHECK FAILED at %0t: %s is %h, expected %h",
                                  $time, what, got, exp));
   endtask

   task automatic check_paddr(input paddr_t got, input paddr_t exp, input string what);
      if (got !== exp)
         report_failure($sformatf("CHECK FAILED at %0t: %s is %h, expected %h",
                                  $time, what, got, exp));
   endtask

   task automatic check_fail(input logic got, input logic exp, input string what);
      if (got !== exp)
         report_failure($sformatf("CHECK FAILED at %0t: %s page_fail is %b, expected %b",
                                  $time, what, got, exp));
   endtask

   task automatic reg_write(input reg_sel_t sel, input word_t data);
      io_sel        = sel;
      io_write_data = data;
      io_write      = 1'b1;
      @(posedge clk);
      #1;
      io_write = 1'b0;
   endtask

   task automatic reg_read(input reg_sel_t sel, output word_t data);
      io_sel  = sel;
      io_read = 1'b1;
      @(posedge clk);
      #1;
      io_read = 1'b0;
      data    = io_read_data;   // registered on the edge just passed
   endtask

   // holds the request until either ack and samples the result on that edge
   task automatic run_access(input logic user, input logic write, input vaddr_t addr,
                             input word_t data, output word_t rdata, output paddr_t paddr,
                             output logic fail);
      int   waited;
      logic acked;
      waited         = 0;
      acked          = 1'b0;
      mem_user       = user;
      mem_addr       = addr;
      mem_write_data = data;
      mem_read       = !write;
      mem_write      = write;
      while (!acked) begin
         @(posedge clk);
         if (read_ack || write_ack) begin
            acked = 1'b1;
            if (write_ack !== write)
               report_failure("the ack does not match the kind of access");
            rdata = mem_read_data;
            paddr = pmem_addr;
            fail  = page_fail;
         end else begin
            waited++;
            if (waited > TIMEOUT)
               report_failure("timeout waiting for a memory access ack");
         end
      end
      #1;
      mem_read  = 1'b0;
      mem_write = 1'b0;
   endtask

   task automatic run_script();
      int     fd;
      int     n;
      int     op;
      int     user;
      int     fail_exp;
      string  line;
      logic [PADDR_W-1:0] addr;
      paddr_t paddr_exp;
      word_t  data;
      word_t  rdata;
      paddr_t paddr;
      logic   fail;
      fd = $fopen("verification/pager_input.txt", "r");
      if (fd == 0)
         report_failure("cannot open the stimulus file");
      while (!$feof(fd)) begin
         line = "";
         n = $fgets(line, fd);
         if (n > 1 && line.getc(0) != "#") begin
            n = $sscanf(line, "%h %h %h %h %h %h", op, user, addr, data, paddr_exp, fail_exp);
            if (n != 6)
               report_failure("malformed line in the stimulus file");
            case (op)
               0: pmem[addr] = data;                       // set up a memory word
               1: reg_write(reg_sel_t'(addr), data);
               2: begin
                  reg_read(reg_sel_t'(addr), rdata);
                  check_word(rdata, data, "register read");
               end
               3, 4: begin
                  run_access(user != 0, op == 4, vaddr_t'(addr), data, rdata, paddr, fail);
                  check_fail(fail, fail_exp != 0, "memory access");
                  if (fail_exp == 0) begin
                     check_paddr(paddr, paddr_exp, "physical address");
                     if (op == 3)
                        check_word(rdata, data, "read data");
                  end
               end
               5: check_word(model_word(addr), data, "memory model word");
               6: begin
                  repeat (int'(data)) @(posedge clk);
                  #1;
               end
               default: report_failure("unknown operation in the stimulus file");
            endcase
         end
      end
      $fclose(fd);
   endtask

   initial begin
      reset          = 1'b1;
      mem_addr       = '0;
      mem_user       = 1'b0;
      mem_read       = 1'b0;
      mem_write      = 1'b0;
      mem_write_data = '0;
      io_sel         = '0;
      io_read        = 1'b0;
      io_write       = 1'b0;
      io_write_data  = '0;
      repeat (8) @(posedge clk);
      #1;
      reset = 1'b0;
      repeat (260) @(posedge clk);   // both sweeps finish
      #1;
      run_script();
      if (dut.u_sva.error_count != 0)
         report_failure("a concurrent assertion failed during the run");
      else begin
         $display("test passed");
         $finish;
      end
   end

endmodule

`default_nettype wire

// File: verification/pager_sva.sv
// concurrent assertions on the pager top-level ports and their bind
`timescale 1ns/10ps
`default_nettype none

module pager_sva (
   input logic clk,
   input logic reset,
   input logic read_ack,
   input logic write_ack,
   input logic page_fail,
   input logic pmem_read,
   input logic pmem_write
);

   int error_count = 0;   // failed assertions so far

   ack_exclusive: assert property (@(posedge clk) disable iff (reset)
      !(read_ack && write_ack))
      else begin
         $error("read_ack and write_ack high in the same cycle");
         error_count = error_count + 1;
      end

   fail_with_ack: assert property (@(posedge clk) disable iff (reset)
      page_fail |-> (read_ack || write_ack))
      else begin
         $error("page_fail without an ack");
         error_count = error_count + 1;
      end

   pmem_exclusive: assert property (@(posedge clk) disable iff (reset)
      !(pmem_read && pmem_write))
      else begin
         $error("pmem_read and pmem_write high in the same cycle");
         error_count = error_count + 1;
      end

   // quiet right out of reset
   fail_after_reset: assert property (@(posedge clk) reset |=> !page_fail)
      else begin
         $error("page_fail high in the cycle after reset");
         error_count = error_count + 1;
      end

endmodule

bind pager_top pager_sva u_sva (
   .clk, .reset, .read_ack, .write_ack, .page_fail, .pmem_read, .pmem_write
);

`default_nettype wire

// File: source/pager_top.sv
// pager top level connecting registers, page cache and table walker
`timescale 1ns/10ps
`default_nettype none

module pager_top import pager_pkg::*; (
   input  logic     clk,
   input  logic     reset,
   input  vaddr_t   mem_addr,
   input  logic     mem_user,      // user or exec space
   input  logic     mem_read,
   input  logic     mem_write,
   input  word_t    mem_write_data,
   output word_t    mem_read_data,
   output logic     read_ack,
   output logic     write_ack,
   output logic     page_fail,
   input  reg_sel_t io_sel,
   input  logic     io_read,
   input  logic     io_write,
   input  word_t    io_write_data,
   output word_t    io_read_data,
   output paddr_t   pmem_addr,
   output word_t    pmem_write_data,
   output logic     pmem_read,
   output logic     pmem_write,
   input  word_t    pmem_read_data,
   input  logic     pmem_read_ack,
   input  logic     pmem_write_ack
);

   logic     paging_enable;
   pt_base_t elb;
   pt_base_t ehb;
   pt_base_t ulb;
   pt_base_t uhb;
   logic     fail_valid;
   word_t    fail_word;
   ppn_t     hit_ppn;
   prot_t    hit_prot;
   logic     lookup_user;
   vpage_t   lookup_vpage;

   cache_fill_if fill_bus ();
   invalidate_if inval_bus ();

   assign mem_read_data = pmem_read_data;   // read data is never altered

   pager_regs u_regs (
      .clk, .reset, .io_sel, .io_read, .io_write, .io_write_data,
      .fail_valid, .fail_word, .io_read_data, .paging_enable,
      .elb, .ehb, .ulb, .uhb,
      .inval (inval_bus.source)
   );

   page_cache u_cache (
      .clk, .reset, .lookup_user, .lookup_vpage, .hit_ppn, .hit_prot,
      .cache_fill (fill_bus.sink),
      .inval      (inval_bus.sink)
   );

   table_walker u_walker (
      .clk, .reset, .mem_addr, .mem_user, .mem_read, .mem_write, .mem_write_data,
      .paging_enable, .elb, .ehb, .ulb, .uhb, .hit_ppn, .hit_prot,
      .sweeping_exec (inval_bus.sweeping_exec),
      .sweeping_user (inval_bus.sweeping_user),
      .pmem_read_data, .pmem_read_ack, .pmem_write_ack,
      .read_ack, .write_ack, .page_fail, .pmem_addr, .pmem_write_data,
      .pmem_read, .pmem_write, .fail_valid, .fail_word, .lookup_user, .lookup_vpage,
      .cache_fill (fill_bus.source)
   );

endmodule

`default_nettype wire

// File: source/table_walker.sv
// miss FSM with page-table read, age write-back, protection check, replay and memory mux
`timescale 1ns/10ps
`default_nettype none

module table_walker import pager_pkg::*; (
   input  logic     clk,
   input  logic     reset,
   input  vaddr_t   mem_addr,
   input  logic     mem_user,
   input  logic     mem_read,
   input  logic     mem_write,
   input  word_t    mem_write_data,
   input  logic     paging_enable,
   input  pt_base_t elb,
   input  pt_base_t ehb,
   input  pt_base_t ulb,
   input  pt_base_t uhb,
   input  ppn_t     hit_ppn,
   input  prot_t    hit_prot,
   input  logic     sweeping_exec,
   input  logic     sweeping_user,
   input  word_t    pmem_read_data,
   input  logic     pmem_read_ack,
   input  logic     pmem_write_ack,
   output logic     read_ack,
   output logic     write_ack,
   output logic     page_fail,
   output paddr_t   pmem_addr,
   output word_t    pmem_write_data,
   output logic     pmem_read,
   output logic     pmem_write,
   output logic     fail_valid,
   output word_t    fail_word,
   output logic     lookup_user,
   output vpage_t   lookup_vpage,
   cache_fill_if.source cache_fill
);

   typedef enum logic [2:0] {IDLE, PTE_WAIT, PTE_CHECK, AGE_WAIT, REPLAY, REPLAY_WAIT} state_t;

   state_t   state;
   state_t   next_state;
   logic     miss;
   logic     save_request;
   vaddr_t   saved_addr;
   logic     saved_user;
   logic     saved_write;
   word_t    saved_data;
   word_t    saved_pte;
   vpage_t   saved_vpage;
   pt_base_t pte_base;
   paddr_t   pte_addr;
   paddr_t   mapped_addr;
   paddr_t   replay_addr;
   logic [PT_HALF_W-1:0] pte_half;
   prot_t    pte_prot;
   ppn_t     pte_ppn;
   logic     pte_age;
   word_t    age_mask;
   logic     prot_fail;
   logic     replay_done;

   assign lookup_user  = mem_user;
   assign lookup_vpage = mem_addr[VADDR_W-1 -: VPAGE_W];

   // unpaged addresses are just zero-extended
   assign mapped_addr = paging_enable ? {hit_ppn, mem_addr[OFFSET_W-1:0]} : paddr_t'(mem_addr);
   assign miss = paging_enable && (mem_read || mem_write) &&
                 ((mem_user ? sweeping_user : sweeping_exec) ||
                  (mem_read && hit_prot == PROT_NONE) ||
                  (mem_write && hit_prot != PROT_RW));

   assign saved_vpage = saved_addr[VADDR_W-1 -: VPAGE_W];
   always_comb begin
      case ({saved_user, saved_vpage[VPAGE_HIGH_BIT]})
         2'b00:   pte_base = elb;
         2'b01:   pte_base = ehb;
         2'b10:   pte_base = ulb;
         default: pte_base = uhb;
      endcase
   end
   assign pte_addr = {pte_base, saved_vpage[VPAGE_HIGH_BIT-1 -: PT_INDEX_W]};

   // odd pages live in the right half of the table word
   assign pte_half = saved_vpage[VPAGE_RIGHT_BIT] ? saved_pte[PT_HALF_W-1:0]
                                                  : saved_pte[WORD_W-1 -: PT_HALF_W];
   assign pte_prot = pte_half[PT_PROT_LSB +: PROT_W];
   assign pte_age  = pte_half[PT_AGE_BIT];
   assign pte_ppn  = pte_half[PPN_W-1:0];
   assign age_mask = word_t'(1) << (saved_vpage[VPAGE_RIGHT_BIT] ? PT_AGE_BIT
                                                                 : PT_AGE_BIT + PT_HALF_W);
   assign prot_fail   = (pte_prot == PROT_NONE) || (saved_write && pte_prot != PROT_RW);
   assign replay_addr = {pte_ppn, saved_addr[OFFSET_W-1:0]};
   assign replay_done = saved_write ? pmem_write_ack : pmem_read_ack;

   assign cache_fill.user  = saved_user;
   assign cache_fill.vpage = saved_vpage;
   assign cache_fill.ppn   = pte_ppn;
   assign cache_fill.prot  = pte_prot;

   always_comb begin
      fail_word = '0;
      fail_word[ERR_WRITE_BIT] = saved_write;
      fail_word[ERR_USER_BIT]  = saved_user;
      fail_word[ERR_PROT_LSB +: PROT_W] = pte_prot;
      fail_word[VADDR_W-1:0]   = saved_addr;
   end

   always_ff @(posedge clk) begin
      if (reset)
         state <= IDLE;
      else
         state <= next_state;
   end

   always_ff @(posedge clk) begin
      if (save_request) begin
         saved_addr  <= mem_addr;
         saved_user  <= mem_user;
         saved_write <= mem_write;
         saved_data  <= mem_write_data;
      end
      if (state == PTE_WAIT && pmem_read_ack)
         saved_pte <= pmem_read_data;
   end

   always_comb begin
      next_state      = state;
      save_request    = 1'b0;
      pmem_addr       = mapped_addr;
      pmem_write_data = mem_write_data;
      pmem_read       = 1'b0;
      pmem_write      = 1'b0;
      read_ack        = 1'b0;
      write_ack       = 1'b0;
      page_fail       = 1'b0;
      fail_valid      = 1'b0;
      cache_fill.fill = 1'b0;
      case (state)
         IDLE: begin
            if (miss) begin
               save_request = 1'b1;
               next_state   = PTE_WAIT;
            end else begin            // hit or unpaged, straight through
               pmem_read = mem_read;
               pmem_write = mem_write;
               read_ack  = pmem_read_ack;
               write_ack = pmem_write_ack;
            end
         end
         PTE_WAIT: begin
            pmem_addr = pte_addr;
            pmem_read = 1'b1;
            if (pmem_read_ack)
               next_state = PTE_CHECK;
         end
         PTE_CHECK: begin
            cache_fill.fill = 1'b1;
            next_state = pte_age ? AGE_WAIT : REPLAY;
         end
         AGE_WAIT: begin
            pmem_addr       = pte_addr;
            pmem_write_data = saved_pte & ~age_mask;
            pmem_write      = 1'b1;
            if (pmem_write_ack)
               next_state = REPLAY;
         end
         REPLAY, REPLAY_WAIT: begin
            if (state == REPLAY && prot_fail) begin
               // complete the access so the processor can take the fault
               page_fail  = 1'b1;
               fail_valid = 1'b1;
               read_ack   = !saved_write;
               write_ack  = saved_write;
               next_state = IDLE;
            end else begin
               pmem_addr       = replay_addr;
               pmem_write_data = saved_data;
               pmem_read       = !saved_write;
               pmem_write      = saved_write;
               read_ack        = !saved_write && pmem_read_ack;
               write_ack       = saved_write && pmem_write_ack;
               next_state      = replay_done ? IDLE : REPLAY_WAIT;
            end
         end
         default: next_state = IDLE;
      endcase
   end

endmodule

`default_nettype wire

// File: source/page_cache.sv
// exec and user page caches with lookup, fill, single invalidate and bulk sweeps
`timescale 1ns/10ps
`default_nettype none

module page_cache import pager_pkg::*; (
   input  logic   clk,
   input  logic   reset,
   input  logic   lookup_user,
   input  vpage_t lookup_vpage,
   output ppn_t   hit_ppn,
   output prot_t  hit_prot,
   cache_fill_if.sink cache_fill,
   invalidate_if.sink inval
);

   // index 0 is the exec space, 1 the user space
   wire [1:0]             fill_space;
   wire [1:0]             single_space;
   wire [1:0]             bulk_req;
   wire [1:0]             sweeping;
   wire [1:0][PPN_W-1:0]  space_ppn;
   wire [1:0][PROT_W-1:0] space_prot;

   assign fill_space   = {cache_fill.user, !cache_fill.user};
   assign single_space = {inval.user, inval.exec};
   assign bulk_req     = {inval.bulk_user, inval.bulk_exec};

   for (genvar s = 0; s < 2; s++) begin : g_space
      ppn_t   ppn_mem  [CACHE_ENTRIES];
      prot_t  prot_mem [CACHE_ENTRIES];   // PROT_NONE marks an empty entry
      vpage_t sweep_count;
      logic   sweep_active;
      logic   fill_here;
      logic   inval_here;

      // fills are lost while the space is being flushed
      assign fill_here  = cache_fill.fill && fill_space[s] && !sweep_active;
      assign inval_here = inval.single && single_space[s];

      always_ff @(posedge clk) begin
         if (reset || bulk_req[s]) begin
            sweep_active <= 1'b1;
            sweep_count  <= '0;
         end else if (sweep_active) begin
            sweep_count <= sweep_count + 1'b1;
            if (sweep_count == vpage_t'(CACHE_ENTRIES - 1))
               sweep_active <= 1'b0;       // last entry cleared this cycle
         end
      end

      // later writes take priority within a cycle
      always_ff @(posedge clk) begin
         if (fill_here) begin
            ppn_mem[cache_fill.vpage]  <= cache_fill.ppn;
            prot_mem[cache_fill.vpage] <= cache_fill.prot;
         end
         if (inval_here)
            prot_mem[inval.vpage] <= PROT_NONE;
         if (sweep_active)
            prot_mem[sweep_count] <= PROT_NONE;  // one entry per cycle
      end

      assign space_ppn[s]  = ppn_mem[lookup_vpage];
      assign space_prot[s] = prot_mem[lookup_vpage];
      assign sweeping[s]   = sweep_active;
   end

   assign hit_ppn  = space_ppn[lookup_user];
   assign hit_prot = space_prot[lookup_user];

   assign inval.sweeping_exec = sweeping[0];
   assign inval.sweeping_user = sweeping[1];

endmodule

`default_nettype wire

// File: source/pager_regs.sv
// pager register file with invalidate command decode and last-error capture
`timescale 1ns/10ps
`default_nettype none

module pager_regs import pager_pkg::*; (
   input  logic     clk,
   input  logic     reset,
   input  reg_sel_t io_sel,
   input  logic     io_read,
   input  logic     io_write,
   input  word_t    io_write_data,
   input  logic     fail_valid,
   input  word_t    fail_word,
   output word_t    io_read_data,
   output logic     paging_enable,
   output pt_base_t elb,
   output pt_base_t ehb,
   output pt_base_t ulb,
   output pt_base_t uhb,
   invalidate_if.source inval
);

   word_t    last_error;
   pt_base_t write_base;
   logic     inval_write;
   logic     bulk_cmd;

   assign write_base  = io_write_data[BASE_LSB +: PT_BASE_W];
   assign inval_write = io_write && (io_sel == REG_INVAL);
   assign bulk_cmd    = inval_write && !io_write_data[INV_SINGLE];

   // commands land in the cache on the clock that takes the write
   assign inval.single = inval_write && io_write_data[INV_SINGLE];
   assign inval.exec   = io_write_data[INV_EXEC];
   assign inval.user   = io_write_data[INV_USER];
   assign inval.vpage  = io_write_data[INV_PAGE_LSB +: VPAGE_W];

   // a new segment base flushes its whole space
   assign inval.bulk_exec = (bulk_cmd && io_write_data[INV_EXEC]) ||
                            (io_write && (io_sel == REG_ELB || io_sel == REG_EHB));
   assign inval.bulk_user = (bulk_cmd && io_write_data[INV_USER]) ||
                            (io_write && (io_sel == REG_ULB || io_sel == REG_UHB));

   always_ff @(posedge clk) begin
      if (reset) begin
         paging_enable <= 1'b0;
         last_error    <= '0;
         elb           <= '0;
         ehb           <= '0;
         ulb           <= '0;
         uhb           <= '0;
      end else begin
         if (io_write) begin
            case (io_sel)
               REG_STATUS: paging_enable <= io_write_data[STATUS_ENABLE];
               REG_ERROR:  last_error    <= io_write_data;
               REG_ELB:    elb           <= write_base;
               REG_EHB:    ehb           <= write_base;
               REG_ULB:    ulb           <= write_base;
               REG_UHB:    uhb           <= write_base;
               default: ;                // inval is a command only
            endcase
         end
         if (fail_valid)
            last_error <= fail_word;     // page fail wins over a software write
      end
   end

   always_ff @(posedge clk) begin
      if (io_read) begin
         case (io_sel)
            REG_STATUS: io_read_data <= word_t'(paging_enable) << STATUS_ENABLE;
            REG_ERROR:  io_read_data <= last_error;
            REG_ELB:    io_read_data <= word_t'(elb) << BASE_LSB;
            REG_EHB:    io_read_data <= word_t'(ehb) << BASE_LSB;
            REG_ULB:    io_read_data <= word_t'(ulb) << BASE_LSB;
            REG_UHB:    io_read_data <= word_t'(uhb) << BASE_LSB;
            default:    io_read_data <= '0;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: source/pager_ifs.sv
// cache fill and invalidate interfaces
`timescale 1ns/10ps
`default_nettype none

// walker to page cache, one entry per fill strobe
interface cache_fill_if import pager_pkg::*; ();
   logic   fill;
   logic   user;
   vpage_t vpage;
   ppn_t   ppn;
   prot_t  prot;

   modport source (output fill, output user, output vpage, output ppn, output prot);
   modport sink   (input fill, input user, input vpage, input ppn, input prot);
endinterface

// register file to page cache, sweep status comes back
interface invalidate_if import pager_pkg::*; ();
   logic   single;         // clear one page, qualified by exec and user
   logic   exec;
   logic   user;
   vpage_t vpage;
   logic   bulk_exec;      // restart the exec sweep
   logic   bulk_user;
   logic   sweeping_exec;
   logic   sweeping_user;

   modport source (
      output single, output exec, output user, output vpage,
      output bulk_exec, output bulk_user,
      input  sweeping_exec, input sweeping_user
   );
   modport sink (
      input  single, input exec, input user, input vpage,
      input  bulk_exec, input bulk_user,
      output sweeping_exec, output sweeping_user
   );
endinterface

`default_nettype wire

// File: source/pager_pkg.sv
// pager widths, types, register indices, protection codes and page-table field positions
`default_nettype none

package pager_pkg;

   localparam int WORD_W     = 36;
   localparam int VADDR_W    = 18;
   localparam int VPAGE_W    = 8;
   localparam int OFFSET_W   = 10;
   localparam int PPN_W      = 12;
   localparam int PADDR_W    = PPN_W + OFFSET_W;
   localparam int PT_BASE_W  = 16;
   localparam int PT_INDEX_W = 6;
   localparam int PROT_W     = 2;
   localparam int REG_SEL_W  = 3;
   localparam int CACHE_ENTRIES = 256;   // one entry per virtual page

   typedef logic [WORD_W-1:0]    word_t;
   typedef logic [VADDR_W-1:0]   vaddr_t;    // vpage in the top 8 bits, offset below
   typedef logic [VPAGE_W-1:0]   vpage_t;
   typedef logic [PPN_W-1:0]     ppn_t;
   typedef logic [PADDR_W-1:0]   paddr_t;    // {ppn, offset}
   typedef logic [PT_BASE_W-1:0] pt_base_t;  // page-table word is at {base, index}
   typedef logic [PROT_W-1:0]    prot_t;
   typedef logic [REG_SEL_W-1:0] reg_sel_t;

   // codes 1 and 2 are read only
   localparam prot_t PROT_NONE = 2'd0;
   localparam prot_t PROT_RW   = 2'd3;

   localparam reg_sel_t REG_STATUS = 3'd0;
   localparam reg_sel_t REG_ERROR  = 3'd1;
   localparam reg_sel_t REG_INVAL  = 3'd2;
   localparam reg_sel_t REG_ELB    = 3'd4;
   localparam reg_sel_t REG_EHB    = 3'd5;
   localparam reg_sel_t REG_ULB    = 3'd6;
   localparam reg_sel_t REG_UHB    = 3'd7;

   // virtual page fields: high segment, page-table index, right half
   localparam int VPAGE_HIGH_BIT  = 7;
   localparam int VPAGE_RIGHT_BIT = 0;

   // one page-table half, left half maps the even page
   localparam int PT_HALF_W   = 18;
   localparam int PT_PROT_LSB = 16;
   localparam int PT_AGE_BIT  = 13;     // ppn sits in the low 12 bits

   localparam int INV_SINGLE   = 0;
   localparam int INV_EXEC     = 1;
   localparam int INV_USER     = 2;
   localparam int INV_PAGE_LSB = 10;    // page to clear in bits 17:10

   localparam int STATUS_ENABLE = 0;
   localparam int BASE_LSB      = PT_INDEX_W; // base registers read as table address

   localparam int ERR_WRITE_BIT = 35;
   localparam int ERR_USER_BIT  = 34;
   localparam int ERR_PROT_LSB  = 32;   // vaddr in the low 18 bits

endpackage

`default_nettype wire
